// ==== d_x_if.sv ====
`include "exec_params.svh"

interface d_x_if
  import exec_pkg::*;
();

  // Handshake
  logic                            val;
  logic                            rdy;

  // Operation and operands
  uop_e                            uop;
  logic [31:0]                     pc;
  logic [31:0]                     op1;
  // Immediate for jumps
  logic [31:0]                     op2;

  // Destination and tracking
  logic [4:0]                      waddr;
  logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;

  // Dispatch side, owns val and payload
  modport dispatch (
    output val, uop, pc, op1, op2,
    output waddr, seq_num, preg, ppreg,
    input  rdy
  );

  // Execute lane side, owns rdy
  modport lane (
    input  val, uop, pc, op1, op2,
    input  waddr, seq_num, preg, ppreg,
    output rdy
  );

endinterface

// ==== exec_cluster.sv ====
`include "exec_params.svh"

module exec_cluster
  import exec_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  // ------------------------------
  // Micro-op input
  // ------------------------------
  input  logic                            in_val,
  output logic                            in_rdy,
  input  uop_e                            in_uop,
  input  logic [31:0]                     in_pc,
  input  logic [31:0]                     in_op1,
  input  logic [31:0]                     in_op2,
  input  logic [4:0]                      in_waddr,
  input  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_preg,
  input  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_ppreg,

  // ------------------------------
  // Writeback output
  // ------------------------------
  output logic                            out_val,
  input  logic                            out_rdy,
  output logic [31:0]                     out_pc,
  output logic [4:0]                      out_waddr,
  output logic [31:0]                     out_wdata,
  output logic                            out_wen,
  output logic [`EXEC_SEQ_NUM_BITS-1:0]   out_seq_num,
  output logic [`EXEC_PHYS_ADDR_BITS-1:0] out_preg,
  output logic [`EXEC_PHYS_ADDR_BITS-1:0] out_ppreg,
  output logic                            out_redirect,
  output logic [31:0]                     out_target
);

  // Dispatch to lane, and lane to arbiter
  d_x_if dx [`EXEC_NUM_LANES] ();
  x_w_if xw [`EXEC_NUM_LANES] ();

  issue_dispatch dispatch_i (
    .clk,
    .rst,
    .in_val,
    .in_rdy,
    .in_uop,
    .in_pc,
    .in_op1,
    .in_op2,
    .in_waddr,
    .in_preg,
    .in_ppreg,
    .lanes    (dx)
  );

  // Identical lanes, one per channel pair
  for (genvar i = 0; i < `EXEC_NUM_LANES; i++) begin : g_lane
    exec_lane lane_i (
      .clk,
      .rst,
      .d   (dx[i]),
      .w   (xw[i])
    );
  end

  writeback_arbiter arb_i (
    .clk,
    .rst,
    .lanes        (xw),
    .out_val,
    .out_rdy,
    .out_pc,
    .out_waddr,
    .out_wdata,
    .out_wen,
    .out_seq_num,
    .out_preg,
    .out_ppreg,
    .out_redirect,
    .out_target
  );

endmodule

// ==== exec_cluster_sva.sv ====
`include "exec_params.svh"

module exec_cluster_sva
  import exec_pkg::*;
(
  input logic                            clk,
  input logic                            rst,
  input logic                            in_val,
  input logic                            in_rdy,
  input uop_e                            in_uop,
  input logic [31:0]                     in_pc,
  input logic [31:0]                     in_op1,
  input logic [31:0]                     in_op2,
  input logic [4:0]                      in_waddr,
  input logic [`EXEC_PHYS_ADDR_BITS-1:0] in_preg,
  input logic [`EXEC_PHYS_ADDR_BITS-1:0] in_ppreg,
  input logic                            out_val,
  input logic                            out_rdy,
  input logic [31:0]                     out_pc,
  input logic [4:0]                      out_waddr,
  input logic [31:0]                     out_wdata,
  input logic                            out_wen,
  input logic [`EXEC_SEQ_NUM_BITS-1:0]   out_seq_num,
  input logic [`EXEC_PHYS_ADDR_BITS-1:0] out_preg,
  input logic [`EXEC_PHYS_ADDR_BITS-1:0] out_ppreg,
  input logic                            out_redirect,
  input logic [31:0]                     out_target
);

  localparam int in_bits  = 4 + 96 + 5 + 2 * `EXEC_PHYS_ADDR_BITS;
  localparam int out_bits = 32 + 5 + 32 + 1 + `EXEC_SEQ_NUM_BITS
                            + 2 * `EXEC_PHYS_ADDR_BITS + 1 + 32;

  logic [in_bits-1:0]  in_payload;
  logic [out_bits-1:0] out_payload;

  // Number of failed assertions so far
  int fail_count = 0;

  // Whole payloads compared as one vector
  assign in_payload  = {in_uop, in_pc, in_op1, in_op2, in_waddr, in_preg, in_ppreg};
  assign out_payload = {out_pc, out_waddr, out_wdata, out_wen, out_seq_num,
                        out_preg, out_ppreg, out_redirect, out_target};

  // ------------------------------
  // Writeback port
  // ------------------------------

  // Stalled result holds still until taken
  out_stable_a: assert property (@(posedge clk) disable iff (rst)
    out_val && !out_rdy |=> out_val && $stable(out_payload))
  else begin
    $error("writeback result changed or vanished while out_rdy was low");
    fail_count++;
  end

  // Lanes are empty right after reset
  out_idle_a: assert property (@(posedge clk)
    $fell(rst) |-> !out_val)
  else begin
    $error("out_val was high in the first cycle after reset");
    fail_count++;
  end

  // ------------------------------
  // Input port
  // ------------------------------

  // Offered micro-op stays until accepted
  in_held_a: assert property (@(posedge clk) disable iff (rst)
    in_val && !in_rdy |=> in_val && $stable(in_payload))
  else begin
    $error("micro-op was withdrawn or changed before in_rdy rose");
    fail_count++;
  end

endmodule

bind exec_cluster exec_cluster_sva sva_i (
  .clk          (clk),
  .rst          (rst),
  .in_val       (in_val),
  .in_rdy       (in_rdy),
  .in_uop       (in_uop),
  .in_pc        (in_pc),
  .in_op1       (in_op1),
  .in_op2       (in_op2),
  .in_waddr     (in_waddr),
  .in_preg      (in_preg),
  .in_ppreg     (in_ppreg),
  .out_val      (out_val),
  .out_rdy      (out_rdy),
  .out_pc       (out_pc),
  .out_waddr    (out_waddr),
  .out_wdata    (out_wdata),
  .out_wen      (out_wen),
  .out_seq_num  (out_seq_num),
  .out_preg     (out_preg),
  .out_ppreg    (out_ppreg),
  .out_redirect (out_redirect),
  .out_target   (out_target)
);

// ==== exec_cluster_tb.sv ====
`include "exec_params.svh"

module exec_cluster_tb
  import exec_pkg::*;
();

  localparam int num_rows   = 20;
  localparam int sb_depth   = 1 << `EXEC_SEQ_NUM_BITS;
  localparam int clk_period = 100;

  // One stimulus row
  // Stall column delays the output of the same index
  typedef struct packed {
    uop_e                            uop;
    logic [31:0]                     pc;
    logic [31:0]                     op1;
    logic [31:0]                     op2;
    logic [4:0]                      waddr;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;
    logic [7:0]                      stall;
    logic                            rnd;
  } row_t;

  // Expected compute outcome
  typedef struct packed {
    logic [31:0] wdata;
    logic        redirect;
    logic [31:0] target;
  } exp_res_t;

  // ------------------------------
  // Stimulus table
  // ------------------------------

  // uop, pc, op1, op2, waddr, preg, ppreg, stall, random operands
  row_t stim [num_rows] = '{
    '{UOP_ADD,  32'h00001000, 32'h00000005, 32'h00000007, 5'd1,  6'd10, 6'd3,  8'd0,  1'b0},
    '{UOP_SUB,  32'h00001004, 32'h00000003, 32'h0000000a, 5'd2,  6'd11, 6'd4,  8'd0,  1'b0},
    '{UOP_AND,  32'h00001008, 32'hf0f0ff00, 32'h0ff00ff0, 5'd3,  6'd12, 6'd5,  8'd1,  1'b0},
    '{UOP_OR,   32'h0000100c, 32'h12340000, 32'h00005678, 5'd0,  6'd13, 6'd6,  8'd0,  1'b0},
    '{UOP_XOR,  32'h00001010, 32'haaaa5555, 32'hffff0000, 5'd4,  6'd14, 6'd7,  8'd0,  1'b0},
    '{UOP_SLT,  32'h00001014, 32'hfffffffe, 32'h00000003, 5'd5,  6'd15, 6'd8,  8'd0,  1'b0},
    '{UOP_SLT,  32'h00001018, 32'h00000005, 32'hffffffff, 5'd6,  6'd16, 6'd9,  8'd0,  1'b0},
    '{UOP_SLT,  32'h0000101c, 32'h80000000, 32'h7fffffff, 5'd7,  6'd17, 6'd10, 8'd3,  1'b0},
    '{UOP_JAL,  32'h00002000, 32'h00000000, 32'h00000100, 5'd1,  6'd18, 6'd11, 8'd0,  1'b0},
    '{UOP_JAL,  32'h00002004, 32'h00000000, 32'hfffffff0, 5'd0,  6'd19, 6'd12, 8'd0,  1'b0},
    '{UOP_JALR, 32'h00002008, 32'h00003001, 32'h00000004, 5'd8,  6'd20, 6'd13, 8'd0,  1'b0},
    '{UOP_JALR, 32'h0000200c, 32'h00004000, 32'h00000003, 5'd9,  6'd21, 6'd14, 8'd0,  1'b0},
    '{UOP_ADD,  32'h00003000, 32'h00000000, 32'h00000000, 5'd10, 6'd22, 6'd15, 8'd12, 1'b1},
    '{UOP_SUB,  32'h00003004, 32'h00000000, 32'h00000000, 5'd11, 6'd23, 6'd16, 8'd0,  1'b1},
    '{UOP_XOR,  32'h00003008, 32'h00000000, 32'h00000000, 5'd12, 6'd24, 6'd17, 8'd0,  1'b1},
    '{UOP_SLT,  32'h0000300c, 32'h00000000, 32'h00000000, 5'd13, 6'd25, 6'd18, 8'd0,  1'b1},
    '{UOP_AND,  32'h00003010, 32'h00000000, 32'h00000000, 5'd14, 6'd26, 6'd19, 8'd0,  1'b1},
    '{UOP_OR,   32'h00003014, 32'h00000000, 32'h00000000, 5'd15, 6'd27, 6'd20, 8'd0,  1'b1},
    '{UOP_JALR, 32'h00003018, 32'h00000000, 32'h00000000, 5'd16, 6'd28, 6'd21, 8'd0,  1'b1},
    '{UOP_ADD,  32'h0000301c, 32'h00000000, 32'h00000000, 5'd0,  6'd29, 6'd22, 8'd2,  1'b1}
  };

  // DUT ports
  logic                            clk;
  logic                            rst;
  logic                            in_val;
  logic                            in_rdy;
  uop_e                            in_uop;
  logic [31:0]                     in_pc;
  logic [31:0]                     in_op1;
  logic [31:0]                     in_op2;
  logic [4:0]                      in_waddr;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_preg;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_ppreg;
  logic                            out_val;
  logic                            out_rdy;
  logic [31:0]                     out_pc;
  logic [4:0]                      out_waddr;
  logic [31:0]                     out_wdata;
  logic                            out_wen;
  logic [`EXEC_SEQ_NUM_BITS-1:0]   out_seq_num;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] out_preg;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] out_ppreg;
  logic                            out_redirect;
  logic [31:0]                     out_target;

  // Scoreboard indexed by sequence number
  logic                            sb_valid [sb_depth];
  exp_res_t                        sb_res   [sb_depth];
  logic [31:0]                     sb_pc    [sb_depth];
  logic [4:0]                      sb_waddr [sb_depth];
  logic [`EXEC_PHYS_ADDR_BITS-1:0] sb_preg  [sb_depth];
  logic [`EXEC_PHYS_ADDR_BITS-1:0] sb_ppreg [sb_depth];

  int   accept_count = 0;
  int   out_count    = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  logic saw_full     = 1'b0;

  tb_clk_gen #(.period(clk_period)) clk_gen_i (.clk(clk));

  exec_cluster dut_i (
    .clk,
    .rst,
    .in_val,
    .in_rdy,
    .in_uop,
    .in_pc,
    .in_op1,
    .in_op2,
    .in_waddr,
    .in_preg,
    .in_ppreg,
    .out_val,
    .out_rdy,
    .out_pc,
    .out_waddr,
    .out_wdata,
    .out_wen,
    .out_seq_num,
    .out_preg,
    .out_ppreg,
    .out_redirect,
    .out_target
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic exp_res_t expected_result(uop_e uop, logic [31:0] pc,
                                               logic [31:0] op1, logic [31:0] op2);
    exp_res_t    r;
    logic [31:0] sum;
    r   = '0;
    sum = op1 + op2;
    case (uop)
      UOP_ADD: r.wdata = sum;
      UOP_SUB: r.wdata = op1 - op2;
      UOP_AND: r.wdata = op1 & op2;
      UOP_OR:  r.wdata = op1 | op2;
      UOP_XOR: r.wdata = op1 ^ op2;
      // Signed compare
      UOP_SLT: r.wdata = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
      UOP_JAL: begin
        r.wdata    = pc + 32'd4;
        r.redirect = 1'b1;
        r.target   = pc + op2;
      end
      UOP_JALR: begin
        r.wdata    = pc + 32'd4;
        r.redirect = 1'b1;
        // Bit 0 of the sum dropped
        r.target   = sum & ~32'd1;
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic int max_stall();
    int m;
    m = 0;
    for (int i = 0; i < num_rows; i++) begin
      if (int'(stim[i].stall) > m)
        m = int'(stim[i].stall);
    end
    return m;
  endfunction

  // ------------------------------
  // Checking helpers
  // ------------------------------

  task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp, int seq);
    assert (got === exp) else begin
      value_errors++;
      $display("FAILED %0t: seq %0d %s is %h, expected %h", $time, seq, name, got, exp);
    end
  endtask

  // Store expectation under the next sequence number
  task automatic record_accept();
    logic [`EXEC_SEQ_NUM_BITS-1:0] seq;
    seq = `EXEC_SEQ_NUM_BITS'(accept_count % sb_depth);
    sb_valid[seq] = 1'b1;
    sb_res[seq]   = expected_result(in_uop, in_pc, in_op1, in_op2);
    sb_pc[seq]    = in_pc;
    sb_waddr[seq] = in_waddr;
    sb_preg[seq]  = in_preg;
    sb_ppreg[seq] = in_ppreg;
    accept_count++;
  endtask

  task automatic check_result();
    int       seq;
    exp_res_t e;
    seq = int'(out_seq_num);
    assert (sb_valid[seq]) else begin
      other_errors++;
      $display("Error at %0t: sequence number %0d is unknown or was delivered twice",
               $time, seq);
    end
    if (sb_valid[seq]) begin
      e = sb_res[seq];
      compare_field("wdata", out_wdata, e.wdata, seq);
      compare_field("redirect", 32'(out_redirect), 32'(e.redirect), seq);
      if (e.redirect)
        compare_field("target", out_target, e.target, seq);
      compare_field("pc", out_pc, sb_pc[seq], seq);
      compare_field("waddr", 32'(out_waddr), 32'(sb_waddr[seq]), seq);
      // Write enable only for a nonzero destination
      compare_field("wen", 32'(out_wen), (sb_waddr[seq] != 5'd0) ? 32'd1 : 32'd0, seq);
      compare_field("preg", 32'(out_preg), 32'(sb_preg[seq]), seq);
      compare_field("ppreg", 32'(out_ppreg), 32'(sb_ppreg[seq]), seq);
      sb_valid[seq] = 1'b0;
    end
    out_count++;
  endtask

  task automatic final_checks();
    for (int i = 0; i < sb_depth; i++) begin
      assert (!sb_valid[i]) else begin
        other_errors++;
        $display("Error: result for sequence number %0d never arrived", i);
      end
    end
    assert (saw_full) else begin
      other_errors++;
      $display("Error: in_rdy never fell during the long output stall");
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d value, %0d other, %0d assertion errors; %0d of %0d results",
             value_errors, other_errors, dut_i.sva_i.fail_count, out_count, num_rows);
  endtask

  // Offer one row and return at the negedge after acceptance
  task automatic apply_row(row_t row);
    int n;
    if (row.rnd) begin
      row.op1 = $urandom();
      row.op2 = $urandom();
    end
    in_val   = 1'b1;
    in_uop   = row.uop;
    in_pc    = row.pc;
    in_op1   = row.op1;
    in_op2   = row.op2;
    in_waddr = row.waddr;
    in_preg  = row.preg;
    in_ppreg = row.ppreg;
    n        = accept_count;
    @(negedge clk);
    while (accept_count == n)
      @(negedge clk);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h854554d4));
    rst      = 1'b1;
    in_val   = 1'b0;
    in_uop   = UOP_ADD;
    in_pc    = '0;
    in_op1   = '0;
    in_op2   = '0;
    in_waddr = '0;
    in_preg  = '0;
    in_ppreg = '0;
    for (int i = 0; i < sb_depth; i++)
      sb_valid[i] = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    // Idle state straight out of reset
    assert (!out_val) else begin
      value_errors++;
      $display("FAILED %0t: out_val is high right after reset", $time);
    end
    assert (in_rdy) else begin
      value_errors++;
      $display("FAILED %0t: in_rdy is low right after reset", $time);
    end
    @(negedge clk);
    for (int r = 0; r < num_rows; r++)
      apply_row(stim[r]);
    in_val = 1'b0;
    while (out_count < num_rows)
      @(negedge clk);
    @(negedge clk);
    final_checks();
    print_summary();
    if (value_errors + other_errors + dut_i.sva_i.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ------------------------------
  // Output drain
  // ------------------------------

  // Stall before output k and stay ready until it is taken
  initial begin
    out_rdy = 1'b0;
    @(posedge clk);
    wait (!rst);
    for (int k = 0; k < num_rows; k++) begin
      if (stim[k].stall != 0) begin
        out_rdy = 1'b0;
        repeat (stim[k].stall) @(negedge clk);
      end
      out_rdy = 1'b1;
      @(negedge clk);
      while (out_count <= k)
        @(negedge clk);
    end
  end

  // ------------------------------
  // Monitor
  // ------------------------------

  // Inputs settle just after the falling edge and hold until the rising edge
  initial begin
    int inflight;
    forever begin
      @(negedge clk);
      #1;
      if (!rst) begin
        inflight = accept_count - out_count;
        assert (inflight <= `EXEC_NUM_LANES) else begin
          other_errors++;
          $display("Error at %0t: %0d micro-ops in flight, more than the lanes hold",
                   $time, inflight);
        end
        if (!in_rdy) begin
          // Back-pressure only once every lane is full
          assert (inflight == `EXEC_NUM_LANES) else begin
            other_errors++;
            $display("Error at %0t: in_rdy low with only %0d lanes busy", $time, inflight);
          end
          if (in_val)
            saw_full = 1'b1;
        end
        if (in_val && in_rdy)
          record_accept();
        if (out_val && out_rdy)
          check_result();
      end
    end
  end

  // ------------------------------
  // Watchdog
  // ------------------------------

  initial begin
    longint unsigned limit;
    limit = longint'(num_rows) * (longint'(max_stall()) + 20) * clk_period;
    #(limit);
    $display("Timeout: run did not finish within %0d time units", limit);
    print_summary();
    $display("Test failed");
    $finish;
  end

endmodule

// ==== exec_lane.sv ====
`include "exec_params.svh"

module exec_lane
  import exec_pkg::*;
(
  input  logic clk,
  input  logic rst,
  d_x_if.lane  d,
  x_w_if.lane  w
);

  // Registered copy of the accepted micro-op
  typedef struct packed {
    uop_e                            uop;
    logic [31:0]                     pc;
    logic [31:0]                     op1;
    logic [31:0]                     op2;
    logic [4:0]                      waddr;
    logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
    logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;
  } lane_entry_t;

  lane_entry_t entry_q;
  logic        val_q;
  logic        d_xfer;
  logic        w_xfer;
  logic [31:0] jalr_sum;

  assign d_xfer = d.val && d.rdy;
  assign w_xfer = w.val && w.rdy;

  // ------------------------------
  // Input register
  // ------------------------------

  // Fill wins over drain, both can happen in one cycle
  always_ff @(posedge clk) begin
    if (rst)
      val_q <= 1'b0;
    else if (d_xfer)
      val_q <= 1'b1;
    else if (w_xfer)
      val_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (d_xfer)
      entry_q <= '{
        uop:     d.uop,
        pc:      d.pc,
        op1:     d.op1,
        op2:     d.op2,
        waddr:   d.waddr,
        seq_num: d.seq_num,
        preg:    d.preg,
        ppreg:   d.ppreg
      };
  end

  // Empty, or emptying this cycle
  assign d.rdy = w.rdy || !val_q;

  // ------------------------------
  // Compute
  // ------------------------------

  assign jalr_sum = entry_q.op1 + entry_q.op2;

  always_comb begin
    w.wdata    = '0;
    w.redirect = 1'b0;
    w.target   = '0;
    case (entry_q.uop)
      UOP_ADD: w.wdata = entry_q.op1 + entry_q.op2;
      UOP_SUB: w.wdata = entry_q.op1 - entry_q.op2;
      UOP_AND: w.wdata = entry_q.op1 & entry_q.op2;
      UOP_OR:  w.wdata = entry_q.op1 | entry_q.op2;
      UOP_XOR: w.wdata = entry_q.op1 ^ entry_q.op2;
      UOP_SLT: w.wdata = {31'b0, $signed(entry_q.op1) < $signed(entry_q.op2)};
      UOP_JAL: begin
        // Link to the next instruction, jump pc-relative
        w.wdata    = entry_q.pc + 32'd4;
        w.redirect = 1'b1;
        w.target   = entry_q.pc + entry_q.op2;
      end
      UOP_JALR: begin
        // Target LSB is always forced low
        w.wdata    = entry_q.pc + 32'd4;
        w.redirect = 1'b1;
        w.target   = {jalr_sum[31:1], 1'b0};
      end
      default: w.wdata = '0;
    endcase
  end

  // Tracking fields pass straight from the register
  assign w.val     = val_q;
  assign w.pc      = entry_q.pc;
  assign w.waddr   = entry_q.waddr;
  // x0 is never written
  assign w.wen     = (entry_q.waddr != 5'd0);
  assign w.seq_num = entry_q.seq_num;
  assign w.preg    = entry_q.preg;
  assign w.ppreg   = entry_q.ppreg;

endmodule

// ==== exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// ------------------------------
// Cluster sizing
// ------------------------------

// Number of execute lanes behind dispatch
// Power of two, so the round-robin pointers wrap naturally
`define EXEC_NUM_LANES 4

// ------------------------------
// Field widths
// ------------------------------

// Sequence number stamped at dispatch
`define EXEC_SEQ_NUM_BITS 5

// Physical register tag
`define EXEC_PHYS_ADDR_BITS 6

`endif

// ==== exec_pkg.sv ====
package exec_pkg;

  // ------------------------------
  // Micro-op opcodes
  // ------------------------------

  // Integer ALU ops first, then the two jumps
  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_SUB  = 4'd1,
    UOP_AND  = 4'd2,
    UOP_OR   = 4'd3,
    UOP_XOR  = 4'd4,
    // Signed compare, result is 0 or 1
    UOP_SLT  = 4'd5,
    // Link plus redirect to pc-relative target
    UOP_JAL  = 4'd6,
    // Link plus redirect to register-relative target
    UOP_JALR = 4'd7
  } uop_e;

  // ------------------------------
  // Writeback arbiter FSM
  // ------------------------------

  // Free picks a new lane each cycle
  // Locked holds the grant while the output is stalled
  typedef enum logic {
    ARB_FREE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_e;

endpackage

// ==== issue_dispatch.sv ====
`include "exec_params.svh"

module issue_dispatch
  import exec_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  // Incoming renamed micro-op
  input  logic                            in_val,
  output logic                            in_rdy,
  input  uop_e                            in_uop,
  input  logic [31:0]                     in_pc,
  input  logic [31:0]                     in_op1,
  input  logic [31:0]                     in_op2,
  input  logic [4:0]                      in_waddr,
  input  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_preg,
  input  logic [`EXEC_PHYS_ADDR_BITS-1:0] in_ppreg,

  // One channel per execute lane
  d_x_if.dispatch                         lanes [`EXEC_NUM_LANES]
);

  localparam int lane_bits = $clog2(`EXEC_NUM_LANES);

  logic [`EXEC_NUM_LANES-1:0]    lane_rdy;
  logic [lane_bits-1:0]          sel;
  logic [lane_bits-1:0]          ptr_q;
  logic [`EXEC_SEQ_NUM_BITS-1:0] seq_q;
  logic                          in_xfer;

  // ------------------------------
  // Lane selection
  // ------------------------------

  // Any free lane can take the micro-op
  assign in_rdy  = |lane_rdy;
  assign in_xfer = in_val && in_rdy;

  // First ready lane at or after the pointer
  always_comb begin
    logic [lane_bits-1:0] cand;
    logic                 found;
    sel   = ptr_q;
    found = 1'b0;
    for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
      cand = ptr_q + lane_bits'(i);
      if (!found && lane_rdy[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
  end

  // ------------------------------
  // Pointer and sequence counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
      seq_q <= '0;
    end else if (in_xfer) begin
      // Next search starts just past the lane that took it
      ptr_q <= sel + 1'b1;
      seq_q <= seq_q + 1'b1;
    end
  end

  // Payload fans out to every lane, val only to the chosen one
  for (genvar i = 0; i < `EXEC_NUM_LANES; i++) begin : g_lane
    assign lane_rdy[i]      = lanes[i].rdy;
    assign lanes[i].val     = in_val && in_rdy && (sel == lane_bits'(i));
    assign lanes[i].uop     = in_uop;
    assign lanes[i].pc      = in_pc;
    assign lanes[i].op1     = in_op1;
    assign lanes[i].op2     = in_op2;
    assign lanes[i].waddr   = in_waddr;
    assign lanes[i].seq_num = seq_q;
    assign lanes[i].preg    = in_preg;
    assign lanes[i].ppreg   = in_ppreg;
  end

endmodule

// ==== list.f ====
+incdir+.
exec_pkg.sv
d_x_if.sv
x_w_if.sv
issue_dispatch.sv
exec_lane.sv
writeback_arbiter.sv
exec_cluster.sv
tb_clk_gen.sv
exec_cluster_sva.sv
exec_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module exec_cluster_tb \
  -f list.f \
  -o exec_cluster_sim

status=0
./obj_dir/exec_cluster_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
fi
echo "run.sh: simulation failed (exit status $status)"
exit 1

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int period = 100
) (
  output logic clk
);

  // Free-running clock, starts low
  initial clk = 1'b0;

  // Toggle every half period
  always #(period / 2) clk = ~clk;

endmodule

// ==== writeback_arbiter.sv ====
`include "exec_params.svh"

module writeback_arbiter
  import exec_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,

  // Results from every lane
  x_w_if.arb                              lanes [`EXEC_NUM_LANES],

  // Single writeback port
  output logic                            out_val,
  input  logic                            out_rdy,
  output logic [31:0]                     out_pc,
  output logic [4:0]                      out_waddr,
  output logic [31:0]                     out_wdata,
  output logic                            out_wen,
  output logic [`EXEC_SEQ_NUM_BITS-1:0]   out_seq_num,
  output logic [`EXEC_PHYS_ADDR_BITS-1:0] out_preg,
  output logic [`EXEC_PHYS_ADDR_BITS-1:0] out_ppreg,
  output logic                            out_redirect,
  output logic [31:0]                     out_target
);

  localparam int lane_bits = $clog2(`EXEC_NUM_LANES);

  // Lane outputs flattened for indexed access
  logic [`EXEC_NUM_LANES-1:0]      lane_val;
  logic [31:0]                     lane_pc       [`EXEC_NUM_LANES];
  logic [4:0]                      lane_waddr    [`EXEC_NUM_LANES];
  logic [31:0]                     lane_wdata    [`EXEC_NUM_LANES];
  logic                            lane_wen      [`EXEC_NUM_LANES];
  logic [`EXEC_SEQ_NUM_BITS-1:0]   lane_seq_num  [`EXEC_NUM_LANES];
  logic [`EXEC_PHYS_ADDR_BITS-1:0] lane_preg     [`EXEC_NUM_LANES];
  logic [`EXEC_PHYS_ADDR_BITS-1:0] lane_ppreg    [`EXEC_NUM_LANES];
  logic                            lane_redirect [`EXEC_NUM_LANES];
  logic [31:0]                     lane_target   [`EXEC_NUM_LANES];

  arb_state_e           state_q;
  logic [lane_bits-1:0] ptr_q;
  logic [lane_bits-1:0] grant_q;
  logic [lane_bits-1:0] pick;
  logic [lane_bits-1:0] sel;
  logic                 out_xfer;

  // ------------------------------
  // Grant selection
  // ------------------------------

  // First valid lane at or after the pointer
  always_comb begin
    logic [lane_bits-1:0] cand;
    logic                 found;
    pick  = ptr_q;
    found = 1'b0;
    for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
      cand = ptr_q + lane_bits'(i);
      if (!found && lane_val[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // A locked grant overrides the fresh pick
  assign sel      = (state_q == ARB_LOCKED) ? grant_q : pick;
  // Empty pick lands on an invalid lane, so val is low
  assign out_val  = lane_val[sel];
  assign out_xfer = out_val && out_rdy;

  // ------------------------------
  // FSM and pointer
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ARB_FREE;
      grant_q <= '0;
      ptr_q   <= '0;
    end else begin
      case (state_q)
        ARB_FREE: begin
          // Stalled offer, keep it until taken
          if (out_val && !out_rdy) begin
            state_q <= ARB_LOCKED;
            grant_q <= sel;
          end
        end
        ARB_LOCKED: begin
          if (out_rdy)
            state_q <= ARB_FREE;
        end
        default: state_q <= ARB_FREE;
      endcase
      if (out_xfer)
        ptr_q <= sel + 1'b1;
    end
  end

  for (genvar i = 0; i < `EXEC_NUM_LANES; i++) begin : g_lane
    assign lane_val[i]      = lanes[i].val;
    assign lane_pc[i]       = lanes[i].pc;
    assign lane_waddr[i]    = lanes[i].waddr;
    assign lane_wdata[i]    = lanes[i].wdata;
    assign lane_wen[i]      = lanes[i].wen;
    assign lane_seq_num[i]  = lanes[i].seq_num;
    assign lane_preg[i]     = lanes[i].preg;
    assign lane_ppreg[i]    = lanes[i].ppreg;
    assign lane_redirect[i] = lanes[i].redirect;
    assign lane_target[i]   = lanes[i].target;
    // Only the granted lane sees the taken result
    assign lanes[i].rdy     = out_xfer && (sel == lane_bits'(i));
  end

  // Output mux
  assign out_pc       = lane_pc[sel];
  assign out_waddr    = lane_waddr[sel];
  assign out_wdata    = lane_wdata[sel];
  assign out_wen      = lane_wen[sel];
  assign out_seq_num  = lane_seq_num[sel];
  assign out_preg     = lane_preg[sel];
  assign out_ppreg    = lane_ppreg[sel];
  assign out_redirect = lane_redirect[sel];
  assign out_target   = lane_target[sel];

endmodule

// ==== x_w_if.sv ====
`include "exec_params.svh"

interface x_w_if ();

  // Handshake
  logic                            val;
  logic                            rdy;

  // Result payload
  logic [31:0]                     pc;
  logic [4:0]                      waddr;
  logic [31:0]                     wdata;
  logic                            wen;
  logic [`EXEC_SEQ_NUM_BITS-1:0]   seq_num;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] preg;
  logic [`EXEC_PHYS_ADDR_BITS-1:0] ppreg;

  // Jump outcome
  logic                            redirect;
  logic [31:0]                     target;

  // Lane produces the result
  modport lane (
    output val, pc, waddr, wdata, wen,
    output seq_num, preg, ppreg, redirect, target,
    input  rdy
  );

  // Arbiter consumes it
  modport arb (
    input  val, pc, waddr, wdata, wen,
    input  seq_num, preg, ppreg, redirect, target,
    output rdy
  );

endinterface
